// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_led_matrix
FILELIST = vlog.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD)

// File: cmd_decoder/cmd_decoder.sv
/* cmd_decoder
   decode stage, turns received bytes into frame writes and enable levels */

`timescale 1ns/100ps

module cmd_decoder (
    input  logic                    clk_root,
    input  logic                    arst_n,
    input  matrix_pkg::byte_t       rx_byte,
    input  logic                    rx_valid,
    output logic                    wr_en,
    output matrix_pkg::pix_addr_t   wr_addr,
    output matrix_pkg::color_t      wr_data,
    output matrix_pkg::plane_mask_t plane_enable,
    output matrix_pkg::rgb_t        rgb_enable
);

    // byte position within a command
    typedef enum logic [2:0] {
        DEC_IDLE,
        DEC_COL,
        DEC_ROW,
        DEC_RED,
        DEC_GB,
        DEC_BRIGHT,
        DEC_RGB
    } dec_state_t;

    dec_state_t state;

    matrix_pkg::col_t      col_q;
    matrix_pkg::scan_row_t row_q;
    logic                  half_q;  // 1 = bottom half
    logic [3:0]            red_q;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state        <= DEC_IDLE;
            wr_en        <= 1'b0;
            plane_enable <= '1;
            rgb_enable   <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    DEC_IDLE: begin
                        case (rx_byte)
                            matrix_pkg::CMD_PIXEL:      state <= DEC_COL;
                            matrix_pkg::CMD_BRIGHTNESS: state <= DEC_BRIGHT;
                            matrix_pkg::CMD_RGB:        state <= DEC_RGB;
                            default:                    state <= DEC_IDLE; // unknown opcode
                        endcase
                    end
                    DEC_COL:    state <= DEC_ROW;
                    DEC_ROW:    state <= DEC_RED;
                    DEC_RED:    state <= DEC_GB;
                    DEC_GB: begin
                        wr_en <= 1'b1;
                        state <= DEC_IDLE;
                    end
                    DEC_BRIGHT: begin
                        plane_enable <= rx_byte[3:0];
                        state        <= DEC_IDLE;
                    end
                    DEC_RGB: begin
                        rgb_enable <= rx_byte[2:0];
                        state      <= DEC_IDLE;
                    end
                    default: state <= DEC_IDLE;
                endcase
            end
        end
    end

    // payload capture, qualified by the byte position
    always_ff @(posedge clk_root) begin
        if (rx_valid) begin
            case (state)
                DEC_COL: col_q <= rx_byte[5:0]; // truncated to the panel width
                DEC_ROW: begin
                    half_q <= (rx_byte >= matrix_pkg::SCAN_ROWS);
                    row_q  <= rx_byte[3:0];
                end
                DEC_RED: red_q <= rx_byte[3:0];
                DEC_GB: begin
                    wr_addr <= {half_q, row_q, col_q};
                    wr_data <= {red_q, rx_byte};  // green high nibble, blue low
                end
                default: ;
            endcase
        end
    end

endmodule

// File: common/matrix_pkg.sv
/* matrix_pkg
   shared geometry, timing, command codes and types for the LED matrix controller */

package matrix_pkg;

    // panel geometry
    localparam int NUM_COLS  = 64;
    localparam int NUM_ROWS  = 32;
    localparam int SCAN_ROWS = 16; // rows per half, also scan steps

    // four brightness planes, one per color bit
    localparam int COLOR_BITS = 4;

    // plane p shows for BASE_DISPLAY_TICKS << p cycles
    localparam int BASE_DISPLAY_TICKS = 64;

    localparam int CLKS_PER_BIT = 8; // serial bit time in clk_root cycles

    // command opcodes
    localparam logic [7:0] CMD_PIXEL      = 8'h50;
    localparam logic [7:0] CMD_BRIGHTNESS = 8'h42;
    localparam logic [7:0] CMD_RGB        = 8'h45;

    typedef logic [$clog2(NUM_COLS)-1:0]  col_t;
    typedef logic [$clog2(SCAN_ROWS)-1:0] scan_row_t;

    // {half, scan row, column}
    typedef logic [$clog2(NUM_COLS * NUM_ROWS)-1:0] pix_addr_t;

    // {red, green, blue}, 4 bits each
    typedef logic [3*COLOR_BITS-1:0] color_t;

    typedef logic [$clog2(COLOR_BITS)-1:0] plane_t;
    typedef logic [COLOR_BITS-1:0]         plane_mask_t;

    // bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] rgb_t;

    typedef logic [7:0] byte_t;

    typedef enum logic [2:0] {
        FETCH_TOP,
        FETCH_BOTTOM,
        SHIFT_LOW,
        SHIFT_HIGH,
        LATCH,
        DISPLAY
    } scan_state_t;

endpackage

// File: scan_sequencer/scan_sequencer.sv
/* scan_sequencer
   execute stage, walks columns, planes and rows and times latch and display */

`timescale 1ns/100ps

module scan_sequencer (
    input  logic                  clk_root,
    input  logic                  arst_n,
    output matrix_pkg::pix_addr_t rd_addr,
    input  matrix_pkg::color_t    rd_data,
    output matrix_pkg::color_t    pix_top,
    output matrix_pkg::color_t    pix_bottom,
    output matrix_pkg::plane_t    plane,
    output logic                  shift_low,
    output logic                  shift_high,
    output logic                  latch_now,
    output logic                  display_on,
    output matrix_pkg::scan_row_t scan_row
);

    matrix_pkg::scan_state_t state;
    matrix_pkg::col_t        col;
    matrix_pkg::scan_row_t   row;   // row being shifted

    // longest display is BASE_DISPLAY_TICKS << (COLOR_BITS-1)
    logic [$clog2(matrix_pkg::BASE_DISPLAY_TICKS << (matrix_pkg::COLOR_BITS-1)):0] disp_cnt;

    // top read in FETCH_TOP, bottom read from FETCH_BOTTOM on
    assign rd_addr = {state != matrix_pkg::FETCH_TOP, row, col};

    // ram output register still holds the bottom pixel during SHIFT_LOW
    assign pix_bottom = rd_data;

    assign shift_low  = (state == matrix_pkg::SHIFT_LOW);
    assign shift_high = (state == matrix_pkg::SHIFT_HIGH);
    assign latch_now  = (state == matrix_pkg::LATCH);
    assign display_on = (state == matrix_pkg::DISPLAY);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state    <= matrix_pkg::FETCH_TOP;
            col      <= '0;
            row      <= '0;
            plane    <= '0;
            scan_row <= '0;
            disp_cnt <= '0;
        end else begin
            case (state)
                matrix_pkg::FETCH_TOP:    state <= matrix_pkg::FETCH_BOTTOM;
                matrix_pkg::FETCH_BOTTOM: state <= matrix_pkg::SHIFT_LOW;
                matrix_pkg::SHIFT_LOW:    state <= matrix_pkg::SHIFT_HIGH;
                matrix_pkg::SHIFT_HIGH: begin
                    col <= col + 1'b1; // wraps to 0 after the last column
                    if (col == matrix_pkg::col_t'(matrix_pkg::NUM_COLS - 1)) begin
                        state    <= matrix_pkg::LATCH;
                        scan_row <= row; // visible in the LATCH cycle
                    end else begin
                        state <= matrix_pkg::FETCH_TOP;
                    end
                end
                matrix_pkg::LATCH: begin
                    disp_cnt <= $bits(disp_cnt)'((matrix_pkg::BASE_DISPLAY_TICKS << plane) - 1);
                    state    <= matrix_pkg::DISPLAY;
                end
                matrix_pkg::DISPLAY: begin
                    if (disp_cnt == '0) begin
                        state <= matrix_pkg::FETCH_TOP;
                        plane <= plane + 1'b1;
                        if (plane == matrix_pkg::plane_t'(matrix_pkg::COLOR_BITS - 1))
                            row <= row + 1'b1; // 15 wraps to 0
                    end else begin
                        disp_cnt <= disp_cnt - 1'b1;
                    end
                end
                default: state <= matrix_pkg::FETCH_TOP;
            endcase
        end
    end

    // top pixel returns one cycle after its address
    always_ff @(posedge clk_root) begin
        if (state == matrix_pkg::FETCH_BOTTOM)
            pix_top <= rd_data;
    end

endmodule

// File: source/frame_ram.sv
/* frame_ram
   frame memory, one write port and one registered read port */

`timescale 1ns/100ps

module frame_ram (
    input  logic                  clk_root,
    input  logic                  wr_en,
    input  matrix_pkg::pix_addr_t wr_addr,
    input  matrix_pkg::color_t    wr_data,
    input  matrix_pkg::pix_addr_t rd_addr,
    output matrix_pkg::color_t    rd_data
);

    // both halves, 2048 pixels
    matrix_pkg::color_t mem [0:matrix_pkg::NUM_COLS*matrix_pkg::NUM_ROWS-1];

    always_ff @(posedge clk_root) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk_root) begin
        rd_data <= mem[rd_addr]; // one cycle read latency
    end

endmodule

// File: source/led_matrix_top.sv
/* led_matrix_top
   64x32 LED matrix controller, serial in, decode, frame memory, scan, pins */

`timescale 1ns/100ps

module led_matrix_top (
    input  logic                  clk_root,
    input  logic                  arst_n,
    input  logic                  serial_rx,
    output matrix_pkg::rgb_t      rgb_top,
    output matrix_pkg::rgb_t      rgb_bottom,
    output logic                  pixel_clk,
    output logic                  row_latch,
    output logic                  output_enable,
    output matrix_pkg::scan_row_t row_addr
);

    matrix_pkg::byte_t       rx_byte;
    logic                    rx_valid;
    logic                    wr_en;
    matrix_pkg::pix_addr_t   wr_addr;
    matrix_pkg::color_t      wr_data;
    matrix_pkg::plane_mask_t plane_enable;
    matrix_pkg::rgb_t        rgb_enable;
    matrix_pkg::pix_addr_t   rd_addr;
    matrix_pkg::color_t      rd_data;
    matrix_pkg::color_t      pix_top;
    matrix_pkg::color_t      pix_bottom;
    matrix_pkg::plane_t      plane;
    logic                    shift_low;
    logic                    shift_high;
    logic                    latch_now;
    logic                    display_on;
    matrix_pkg::scan_row_t   scan_row;

    uart_rx u_uart_rx (
        .clk_root  (clk_root),
        .arst_n    (arst_n),
        .serial_rx (serial_rx),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    cmd_decoder u_cmd_decoder (
        .clk_root     (clk_root),
        .arst_n       (arst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .plane_enable (plane_enable),
        .rgb_enable   (rgb_enable)
    );

    frame_ram u_frame_ram (
        .clk_root (clk_root),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    scan_sequencer u_scan_sequencer (
        .clk_root   (clk_root),
        .arst_n     (arst_n),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .pix_top    (pix_top),
        .pix_bottom (pix_bottom),
        .plane      (plane),
        .shift_low  (shift_low),
        .shift_high (shift_high),
        .latch_now  (latch_now),
        .display_on (display_on),
        .scan_row   (scan_row)
    );

    pixel_out u_pixel_out (
        .clk_root      (clk_root),
        .arst_n        (arst_n),
        .pix_top       (pix_top),
        .pix_bottom    (pix_bottom),
        .plane         (plane),
        .shift_low     (shift_low),
        .shift_high    (shift_high),
        .latch_now     (latch_now),
        .display_on    (display_on),
        .scan_row      (scan_row),
        .plane_enable  (plane_enable),
        .rgb_enable    (rgb_enable),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .pixel_clk     (pixel_clk),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_addr      (row_addr)
    );

endmodule

// File: source/pixel_out.sv
/* pixel_out
   result stage, plane bit select and enables, registered panel pins */

`timescale 1ns/100ps

module pixel_out (
    input  logic                    clk_root,
    input  logic                    arst_n,
    input  matrix_pkg::color_t      pix_top,
    input  matrix_pkg::color_t      pix_bottom,
    input  matrix_pkg::plane_t      plane,
    input  logic                    shift_low,
    input  logic                    shift_high,
    input  logic                    latch_now,
    input  logic                    display_on,
    input  matrix_pkg::scan_row_t   scan_row,
    input  matrix_pkg::plane_mask_t plane_enable,
    input  matrix_pkg::rgb_t        rgb_enable,
    output matrix_pkg::rgb_t        rgb_top,
    output matrix_pkg::rgb_t        rgb_bottom,
    output logic                    pixel_clk,
    output logic                    row_latch,
    output logic                    output_enable,
    output matrix_pkg::scan_row_t   row_addr
);

    matrix_pkg::rgb_t chan_en;

    // red sits in the top nibble, rgb bit 0 is red
    function automatic matrix_pkg::rgb_t plane_bits(matrix_pkg::color_t px,
                                                    matrix_pkg::plane_t p);
        matrix_pkg::rgb_t bits;
        for (int c = 0; c < 3; c++)
            bits[c] = px[(2 - c) * matrix_pkg::COLOR_BITS + int'(p)];
        return bits;
    endfunction

    assign chan_en = plane_enable[plane] ? rgb_enable : '0;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rgb_top       <= '0;
            rgb_bottom    <= '0;
            pixel_clk     <= 1'b0;
            row_latch     <= 1'b0;
            output_enable <= 1'b0;
            row_addr      <= '0;
        end else begin
            if (shift_low) begin // data settles while pixel_clk is low
                rgb_top    <= plane_bits(pix_top, plane) & chan_en;
                rgb_bottom <= plane_bits(pix_bottom, plane) & chan_en;
            end
            pixel_clk     <= shift_high;
            row_latch     <= latch_now;
            output_enable <= display_on;
            row_addr      <= scan_row;
        end
    end

endmodule

// File: source/uart_rx.sv
/* uart_rx
   8N1 serial byte receiver, samples each bit at its middle */

`timescale 1ns/100ps

module uart_rx (
    input  logic              clk_root,
    input  logic              arst_n,
    input  logic              serial_rx,
    output matrix_pkg::byte_t rx_byte,
    output logic              rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t state;
    logic [1:0] sync;   // two-flop synchronizer, line idles high
    logic [$clog2(matrix_pkg::CLKS_PER_BIT)-1:0] cnt;
    logic [2:0] bit_idx;
    logic       rx_s;

    assign rx_s = sync[1];

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            sync     <= 2'b11;
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_byte  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync     <= {sync[0], serial_rx};
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_s)
                        state <= RX_START;
                end
                RX_START: begin // wait half a bit, recheck the start level
                    if (cnt == $bits(cnt)'(matrix_pkg::CLKS_PER_BIT / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA; // glitch, back to idle
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == $bits(cnt)'(matrix_pkg::CLKS_PER_BIT - 1)) begin
                        cnt     <= '0;
                        rx_byte <= {rx_s, rx_byte[7:1]}; // lsb first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == $bits(cnt)'(matrix_pkg::CLKS_PER_BIT - 1)) begin
                        rx_valid <= rx_s; // framing error drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: tb/tb_led_matrix.sv
/* tb_led_matrix
   random pixel and enable commands over the serial line, panel model checks the scan pins */

`timescale 1ns/100ps

module tb_led_matrix;

    localparam int CLK_HALF = 20; // 40 ns period
    localparam int NUM_PIXELS = 60;
    localparam int LATCHES_PER_FRAME = matrix_pkg::SCAN_ROWS * matrix_pkg::COLOR_BITS;

    // 4 cycles per column plus the latch and the weighted displays of all planes
    localparam int FRAME_CYCLES = matrix_pkg::SCAN_ROWS *
        (matrix_pkg::COLOR_BITS * (4 * matrix_pkg::NUM_COLS + 1) +
         matrix_pkg::BASE_DISPLAY_TICKS * ((1 << matrix_pkg::COLOR_BITS) - 1));
    // about 300 command bytes and four windows of three frames each
    localparam int TEST_CYCLES = 300 * 10 * matrix_pkg::CLKS_PER_BIT + 12 * FRAME_CYCLES;
    localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

    logic                  clk_root;
    logic                  arst_n;
    logic                  serial_rx;
    matrix_pkg::rgb_t      rgb_top;
    matrix_pkg::rgb_t      rgb_bottom;
    logic                  pixel_clk;
    logic                  row_latch;
    logic                  output_enable;
    matrix_pkg::scan_row_t row_addr;

    // reference frame and enables
    matrix_pkg::color_t      model_mem [0:2047];
    bit                      model_written [0:2047];
    matrix_pkg::plane_mask_t model_plane_en;
    matrix_pkg::rgb_t        model_rgb_en;

    logic [31:0] rng_state;
    int          errors;
    int          compares;
    int          cycle_cnt = 0;
    bit          check_on;

    // monitor state
    int               latch_k;
    int               edge_cnt;
    int               oe_len;
    int               cur_plane;
    bit               armed;    // whole collection window ran with checks on
    bit               oe_done;  // display period finished since the last latch
    logic             pclk_q;
    logic             oe_q;
    matrix_pkg::rgb_t top_seen [0:matrix_pkg::NUM_COLS-1];
    matrix_pkg::rgb_t bot_seen [0:matrix_pkg::NUM_COLS-1];

    led_matrix_top u_dut (
        .clk_root      (clk_root),
        .arst_n        (arst_n),
        .serial_rx     (serial_rx),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .pixel_clk     (pixel_clk),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_addr      (row_addr)
    );

    initial begin
        clk_root = 1'b0;
        forever #CLK_HALF clk_root = ~clk_root;
    end

    always @(posedge clk_root) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the scan or serial path stalled", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // plane bit of each channel nibble masked by the enables
    function automatic matrix_pkg::rgb_t expected_bits(matrix_pkg::color_t c, int p);
        matrix_pkg::rgb_t e;
        e[0] = c[8 + p];
        e[1] = c[4 + p];
        e[2] = c[p];
        if (!model_plane_en[p])
            e = '0;
        return e & model_rgb_en;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk_root);
        serial_rx = 1'b0; // start bit
        repeat (matrix_pkg::CLKS_PER_BIT) @(negedge clk_root);
        for (int i = 0; i < 8; i++) begin
            serial_rx = b[i];
            repeat (matrix_pkg::CLKS_PER_BIT) @(negedge clk_root);
        end
        serial_rx = 1'b1;
        repeat (matrix_pkg::CLKS_PER_BIT) @(negedge clk_root);
    endtask

    task automatic write_pixel(input logic [7:0] col, input logic [7:0] row,
                               input matrix_pkg::color_t c);
        logic [31:0]           r;
        matrix_pkg::pix_addr_t a;
        r = next_rand();
        send_byte(matrix_pkg::CMD_PIXEL);
        send_byte(col);
        send_byte(row);
        send_byte({r[7:4], c[11:8]}); // high nibble is don't care
        send_byte(c[7:0]);
        repeat (12) @(negedge clk_root);
        a = {row[4], row[3:0], col[5:0]}; // row 16 and up is the bottom half
        model_mem[a] = c;
        model_written[a] = 1'b1;
    endtask

    task automatic set_planes(input logic [7:0] b);
        send_byte(matrix_pkg::CMD_BRIGHTNESS);
        send_byte(b);
        repeat (12) @(negedge clk_root);
        model_plane_en = b[3:0];
    endtask

    task automatic set_channels(input logic [7:0] b);
        send_byte(matrix_pkg::CMD_RGB);
        send_byte(b);
        repeat (12) @(negedge clk_root);
        model_rgb_en = b[2:0];
    endtask

    task automatic wait_latches(input int n);
        int target;
        target = latch_k + n;
        while (latch_k < target)
            @(posedge clk_root); // monitor updates on the falling edge
    endtask

    // one frame to settle and two checked frames
    task automatic run_window();
        wait_latches(LATCHES_PER_FRAME);
        check_on = 1'b1;
        wait_latches(2 * LATCHES_PER_FRAME);
        check_on = 1'b0;
    endtask

    task automatic compare_row(input int r, input int p);
        matrix_pkg::pix_addr_t a;
        matrix_pkg::rgb_t      want;
        matrix_pkg::rgb_t      seen;
        for (int n = 0; n < matrix_pkg::NUM_COLS; n++) begin
            for (int h = 0; h < 2; h++) begin
                a = {h[0], r[3:0], n[5:0]};
                if (model_written[a]) begin
                    want = expected_bits(model_mem[a], p);
                    seen = h ? bot_seen[n] : top_seen[n];
                    compares++;
                    assert (seen == want) else begin
                        errors++;
                        $display("Error at %0t: row %0d plane %0d col %0d half %0d",
                                 $time, r, p, n, h);
                        $display("    expected %b observed %b", want, seen);
                    end
                end
            end
        end
    endtask

    always @(negedge clk_root) begin
        if (!arst_n) begin
            latch_k   = 0;
            edge_cnt  = 0;
            oe_len    = 0;
            cur_plane = 0;
            armed     = 1'b0;
            oe_done   = 1'b0;
            pclk_q    = 1'b0;
            oe_q      = 1'b0;
        end else begin
            if (pixel_clk && !pclk_q) begin // edge n carries column n
                if (edge_cnt < matrix_pkg::NUM_COLS) begin
                    top_seen[edge_cnt] = rgb_top;
                    bot_seen[edge_cnt] = rgb_bottom;
                end
                edge_cnt++;
            end
            assert (!(pixel_clk && output_enable)) else begin
                errors++;
                $display("Error at %0t: output_enable high while pixel_clk toggles", $time);
            end
            if (latch_k == 0) begin
                assert (!output_enable) else begin
                    errors++;
                    $display("Error at %0t: output_enable high before the first latch", $time);
                end
            end
            if (output_enable)
                oe_len++;
            if (!output_enable && oe_q) begin
                assert (oe_len == (matrix_pkg::BASE_DISPLAY_TICKS << cur_plane)) else begin
                    errors++;
                    $display("Error at %0t: display plane %0d expected %0d cycles observed %0d",
                             $time, cur_plane,
                             matrix_pkg::BASE_DISPLAY_TICKS << cur_plane, oe_len);
                end
                oe_len  = 0;
                oe_done = 1'b1;
            end
            if (row_latch) begin
                assert (edge_cnt == matrix_pkg::NUM_COLS) else begin
                    errors++;
                    $display("Error at %0t: latch %0d expected %0d pixel clocks observed %0d",
                             $time, latch_k, matrix_pkg::NUM_COLS, edge_cnt);
                end
                assert (row_addr == (latch_k / 4) % 16) else begin
                    errors++;
                    $display("Error at %0t: latch %0d expected row %0d observed %0d",
                             $time, latch_k, (latch_k / 4) % 16, row_addr);
                end
                if (latch_k > 0) begin
                    assert (oe_done) else begin
                        errors++;
                        $display("Error at %0t: latch %0d without a display period before it",
                                 $time, latch_k);
                    end
                end
                if (armed && check_on)
                    compare_row((latch_k / 4) % 16, latch_k % 4);
                armed     = check_on;
                oe_done   = 1'b0;
                cur_plane = latch_k % 4;
                edge_cnt  = 0;
                latch_k++;
            end
            pclk_q = pixel_clk;
            oe_q   = output_enable;
        end
    end

    initial begin
        logic [31:0] r;
        arst_n         = 1'b0;
        serial_rx      = 1'b1; // line idle
        check_on       = 1'b0;
        errors         = 0;
        compares       = 0;
        rng_state      = 32'd75531;
        model_plane_en = '1;
        model_rgb_en   = '1;
        for (int i = 0; i < 2048; i++)
            model_written[i] = 1'b0;
        repeat (2) @(negedge clk_root);
        assert (!pixel_clk && !row_latch && !output_enable) else begin
            errors++;
            $display("Error at %0t: panel controls not low after reset", $time);
        end
        arst_n = 1'b1;

        for (int i = 0; i < NUM_PIXELS; i++) begin
            r = next_rand();
            write_pixel(r[7:0], {3'b000, r[12:8]}, r[27:16]);
        end
        run_window();

        r = next_rand();
        set_planes(r[7:0]);
        run_window();

        set_planes(8'h0f);
        send_byte(8'h7a); // unknown opcode leaves the decoder idle
        r = next_rand();
        set_channels(r[7:0]);
        run_window();

        r = next_rand();
        set_planes(r[7:0]);
        r = next_rand();
        set_channels(r[7:0]);
        run_window();

        if (compares == 0) begin
            errors++;
            $display("no pixel was compared, the checking windows saw no written entries");
        end
        $display("errors %0d, pixel compares %0d", errors, compares);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: vlog.f
common/matrix_pkg.sv
source/uart_rx.sv
source/frame_ram.sv
source/pixel_out.sv
source/led_matrix_top.sv
cmd_decoder/cmd_decoder.sv
scan_sequencer/scan_sequencer.sv
tb/tb_led_matrix.sv
